/* bench/bus_patterns.txt */
# op addr(hex) len(hex) data(hex) strb(hex) resp-or-direction; beat k data = data + k*01010101
# button lines: len is the press count, direction up, down or both
write 20000000 00 a5a5a5a5 f okay
write 20000004 00 12345678 3 okay
write 20000008 00 cafef00d c okay
write 2000000c 00 deadbeef 5 okay
read 20000000 00 00000000 0 okay
read 20000004 00 00000000 0 okay
read 20000008 00 00000000 0 okay
read 2000000c 00 00000000 0 okay
write 20000010 03 11223344 f okay
read 20000000 03 00000000 0 okay
write 00000000 01 ffffffff f decerr
write 10000000 00 ffffffff f decerr
write 30000000 02 ffffffff f decerr
read 00000000 00 00000000 0 decerr
read 10000000 01 00000000 0 decerr
read 30000000 03 00000000 0 decerr
read 2fffff0c 00 00000000 0 okay
read 2fffff10 00 00000000 0 decerr
read 20000000 03 00000000 0 okay
button 00000000 01 00000000 0 down
button 00000000 01 00000000 0 up
button 00000000 05 00000000 0 up
button 00000000 02 00000000 0 both
button 00000000 07 00000000 0 down
button 00000000 03 00000000 0 up

/* filelist.f */
common/bus_pkg.sv
common/led_pkg.sv
bus/burst_counter.sv
bus/bus_fsm.sv
src/led_reg_slave.sv
src/led_page_display.sv
src/axi_led_top.sv
bench/axi_led_checker.sv
bench/tb_axi_led_top.sv

/* Bender.yml */
package:
  name: axi_led

sources:
  - common/bus_pkg.sv
  - common/led_pkg.sv
  - bus/burst_counter.sv
  - bus/bus_fsm.sv
  - src/led_reg_slave.sv
  - src/led_page_display.sv
  - src/axi_led_top.sv
  - target: test
    files:
      - bench/axi_led_checker.sv
      - bench/tb_axi_led_top.sv

/* bench/tb_axi_led_top.sv */
`timescale 1ns/10ps

module tb_axi_led_top;
    import bus_pkg::*;
    import led_pkg::*;

    localparam int    CLK_PERIOD = 40;
    localparam addr_t LED_START  = 32'h2000_0000;
    localparam addr_t LED_END    = 32'h2fff_ff0f;

    logic      sys_clk;
    logic      rst_n;
    aw_t       aw;
    logic      aw_ready;
    w_t        w;
    logic      w_ready;
    b_t        b;
    logic      b_ready;
    ar_t       ar;
    logic      ar_ready;
    r_t        r;
    logic      r_ready;
    logic      btn_up;
    logic      btn_down;
    led_byte_t led8;
    page_idx_t led4;

    data_t       shadow [REG_COUNT];    // register model
    page_idx_t   idx_model;
    int          err_count;
    bit          loaded;
    logic [63:0] op_q [$];
    addr_t       addr_q [$];
    len_t        len_q [$];
    data_t       data_q [$];
    strb_t       strb_q [$];
    logic [63:0] tag_q [$];

    axi_led_top #(
        .LED_START_ADDR (LED_START),
        .LED_END_ADDR   (LED_END)
    ) i_dut (.*);

    initial begin
        sys_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
        end
    end

    function automatic logic in_window(input addr_t a);
        return a >= LED_START && a <= LED_END;
    endfunction

    // beat k of a burst carries its own word
    function automatic data_t beat_data(input data_t base, input int k);
        return base + data_t'(k) * 32'h0101_0101;
    endfunction

    function automatic led_byte_t model_byte(input page_idx_t i);
        return shadow[i / 4][8 * (i % 4) +: 8];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("Error at %0d ns: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic load_patterns();
        int          fd;
        int          cnt;
        string       line;
        logic [63:0] op;
        logic [63:0] tag;
        addr_t       a;
        len_t        l;
        data_t       d;
        strb_t       s;
        fd = $fopen("bench/bus_patterns.txt", "r");
        if (fd == 0) begin
            err_count++;
            $display("could not open bench/bus_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                cnt = $fgets(line, fd);
                if (cnt == 0 || line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                cnt = $sscanf(line, "%s %h %h %h %h %s", op, a, l, d, s, tag);
                if (cnt != 6) begin
                    err_count++;
                    $display("malformed pattern line: %s", line);
                end else begin
                    op_q.push_back(op);
                    addr_q.push_back(a);
                    len_q.push_back(l);
                    data_q.push_back(d);
                    strb_q.push_back(s);
                    tag_q.push_back(tag);
                end
            end
            $fclose(fd);
            loaded = 1'b1;
        end
    endtask

    task automatic do_write(input addr_t addr, input len_t len, input data_t data,
                            input strb_t strb, input resp_t exp_resp);
        logic  hit;
        addr_t a;
        data_t d;
        hit = in_window(addr);
        @(posedge sys_clk);
        aw <= '{valid: 1'b1, addr: addr, len: len};
        @(negedge sys_clk);
        check_value("aw_ready", aw_ready, 1'b1);
        while (!aw_ready) begin
            @(negedge sys_clk);
        end
        @(posedge sys_clk);
        aw <= '0;
        for (int k = 0; k <= int'(len); k++) begin
            d = beat_data(data, k);
            w <= '{valid: 1'b1, data: d, strb: strb};
            @(negedge sys_clk);
            check_value("w_ready", w_ready, 1'b1);
            while (!w_ready) begin
                @(negedge sys_clk);
            end
            a = addr + addr_t'(4 * k);
            for (int i = 0; i < 4; i++) begin
                if (hit && strb[i]) begin
                    shadow[a[3:2]][8*i +: 8] = d[8*i +: 8];
                end
            end
            @(posedge sys_clk);
        end
        w       <= '0;
        b_ready <= ($urandom % 4) != 0;
        @(negedge sys_clk);
        check_value("b.valid", b.valid, 1'b1);
        while (!(b.valid && b_ready)) begin
            @(posedge sys_clk);
            b_ready <= ($urandom % 4) != 0;    // random back-pressure
            @(negedge sys_clk);
        end
        check_value("b.resp", b.resp, exp_resp);
        @(posedge sys_clk);
        b_ready <= 1'b0;
        @(negedge sys_clk);
        check_value("b.valid after response", b.valid, 1'b0);
    endtask

    task automatic do_read(input addr_t addr, input len_t len, input resp_t exp_resp);
        logic  hit;
        addr_t a;
        data_t exp_data;
        hit = in_window(addr);
        @(posedge sys_clk);
        ar <= '{valid: 1'b1, addr: addr, len: len};
        @(negedge sys_clk);
        check_value("ar_ready", ar_ready, 1'b1);
        while (!ar_ready) begin
            @(negedge sys_clk);
        end
        @(posedge sys_clk);
        ar      <= '0;
        r_ready <= ($urandom % 4) != 0;
        for (int k = 0; k <= int'(len); k++) begin
            @(negedge sys_clk);
            check_value("r.valid", r.valid, 1'b1);
            while (!(r.valid && r_ready)) begin
                @(posedge sys_clk);
                r_ready <= ($urandom % 4) != 0;
                @(negedge sys_clk);
            end
            a        = addr + addr_t'(4 * k);
            exp_data = hit ? shadow[a[3:2]] : '0;
            check_value("r.data", r.data, exp_data);
            check_value("r.resp", r.resp, exp_resp);
            check_value("r.last", r.last, k == int'(len));
            @(posedge sys_clk);
            r_ready <= (k < int'(len)) && (($urandom % 4) != 0);
        end
        @(negedge sys_clk);
        check_value("r.valid after last beat", r.valid, 1'b0);    // no extra beat
    endtask

    // held for three cycles, so one step per press
    task automatic press_button(input logic up, input logic down);
        @(posedge sys_clk);
        btn_up   <= up;
        btn_down <= down;
        repeat (3) @(posedge sys_clk);
        btn_up   <= 1'b0;
        btn_down <= 1'b0;
        repeat (2) @(posedge sys_clk);
        if (up && !down) begin
            idx_model = idx_model + page_idx_t'(1);
        end else if (down && !up) begin
            idx_model = idx_model - page_idx_t'(1);
        end
        @(negedge sys_clk);
        check_value("led4", led4, idx_model);
        check_value("led8", led8, model_byte(idx_model));
    endtask

    initial begin
        resp_t exp_resp;
        void'($urandom(14783));
        aw        = '0;
        w         = '0;
        ar        = '0;
        b_ready   = 1'b0;
        r_ready   = 1'b0;
        btn_up    = 1'b0;
        btn_down  = 1'b0;
        rst_n     = 1'b0;
        err_count = 0;
        idx_model = '0;
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
        load_patterns();
        repeat (3) @(posedge sys_clk);
        rst_n <= 1'b1;
        @(negedge sys_clk);
        check_value("led4 after reset", led4, 0);
        check_value("led8 after reset", led8, 0);
        check_value("aw_ready after reset", aw_ready, 0);
        check_value("ar_ready after reset", ar_ready, 0);
        check_value("w_ready after reset", w_ready, 0);
        check_value("b.valid after reset", b.valid, 0);
        check_value("r.valid after reset", r.valid, 0);
        foreach (op_q[n]) begin
            exp_resp = (tag_q[n] == "decerr") ? RESP_DECERR : RESP_OKAY;
            if (op_q[n] != "button" && in_window(addr_q[n]) != (exp_resp == RESP_OKAY)) begin
                err_count++;
                $display("pattern %0d: expected response disagrees with the LED window", n);
            end
            if (op_q[n] == "write") begin
                do_write(addr_q[n], len_q[n], data_q[n], strb_q[n], exp_resp);
            end else if (op_q[n] == "read") begin
                do_read(addr_q[n], len_q[n], exp_resp);
            end else if (op_q[n] == "button") begin
                repeat (len_q[n]) begin
                    press_button(tag_q[n] == "up" || tag_q[n] == "both",
                                 tag_q[n] == "down" || tag_q[n] == "both");
                end
            end else begin
                err_count++;
                $display("pattern %0d: unknown operation", n);
            end
        end
        repeat (2) @(posedge sys_clk);
        $display("run complete: %0d check errors, %0d assertion failures",
                 err_count, i_dut.i_checker.fail_count);
        if (err_count == 0 && i_dut.i_checker.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog, 200 cycles per pattern line
    initial begin
        wait (loaded);
        #(longint'(op_q.size()) * 200 * CLK_PERIOD);
        $display("timeout: bus operations did not finish in time, %0d errors so far",
                 err_count);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* bench/axi_led_checker.sv */
`timescale 1ns/10ps

module axi_led_checker (
    input logic        sys_clk,
    input logic        rst_n,
    input logic        aw_ready,
    input logic        ar_ready,
    input logic        w_ready,
    input bus_pkg::b_t b,
    input logic        b_ready,
    input bus_pkg::r_t r,
    input logic        r_ready
);
    import bus_pkg::*;

    int fail_count = 0;

    // responses hold under back-pressure
    assert property (@(posedge sys_clk) disable iff (!rst_n)
        b.valid && !b_ready |=> $stable(b))
    else begin
        fail_count++;
        $error("b changed while waiting for b_ready");
    end

    assert property (@(posedge sys_clk) disable iff (!rst_n)
        r.valid && !r_ready |=> $stable(r))
    else begin
        fail_count++;
        $error("r changed while waiting for r_ready");
    end

    assert property (@(posedge sys_clk) disable iff (!rst_n) !(aw_ready && ar_ready))
    else begin
        fail_count++;
        $error("aw_ready and ar_ready high together");
    end

    assert property (@(posedge sys_clk) disable iff (!rst_n) !(b.valid && r.valid))
    else begin
        fail_count++;
        $error("b.valid and r.valid high together");
    end

    assert property (@(posedge sys_clk) disable iff (!rst_n) !(w_ready && b.valid))
    else begin
        fail_count++;
        $error("w_ready high during write response");
    end

endmodule

bind axi_led_top axi_led_checker i_checker (
    .sys_clk  (sys_clk),
    .rst_n    (rst_n),
    .aw_ready (aw_ready),
    .ar_ready (ar_ready),
    .w_ready  (w_ready),
    .b        (b),
    .b_ready  (b_ready),
    .r        (r),
    .r_ready  (r_ready)
);

/* src/axi_led_top.sv */
`timescale 1ns/10ps

module axi_led_top #(
    parameter bus_pkg::addr_t LED_START_ADDR = 32'h2000_0000,
    parameter bus_pkg::addr_t LED_END_ADDR   = 32'h2fff_ff0f
) (
    input  logic               sys_clk,
    input  logic               rst_n,
    input  bus_pkg::aw_t       aw,
    output logic               aw_ready,
    input  bus_pkg::w_t        w,
    output logic               w_ready,
    output bus_pkg::b_t        b,
    input  logic               b_ready,
    input  bus_pkg::ar_t       ar,
    output logic               ar_ready,
    output bus_pkg::r_t        r,
    input  logic               r_ready,
    input  logic               btn_up,
    input  logic               btn_down,
    output led_pkg::led_byte_t led8,
    output led_pkg::page_idx_t led4
);
    import bus_pkg::*;
    import led_pkg::*;

    logic      burst_load;
    burst_t    burst_start;
    logic      beat_step;
    addr_t     beat_addr;
    logic      beat_last;
    logic      wr_en;
    data_t     wr_data;
    strb_t     wr_strb;
    data_t     rd_data;
    reg_bank_t reg_bank;

    bus_fsm #(
        .LED_START_ADDR (LED_START_ADDR),
        .LED_END_ADDR   (LED_END_ADDR)
    ) u_bus_fsm (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .aw          (aw),
        .aw_ready    (aw_ready),
        .w           (w),
        .w_ready     (w_ready),
        .b           (b),
        .b_ready     (b_ready),
        .ar          (ar),
        .ar_ready    (ar_ready),
        .r           (r),
        .r_ready     (r_ready),
        .burst_load  (burst_load),
        .burst_start (burst_start),
        .beat_step   (beat_step),
        .beat_addr   (beat_addr),
        .beat_last   (beat_last),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .wr_strb     (wr_strb),
        .rd_data     (rd_data)
    );

    burst_counter u_burst_counter (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .burst_load  (burst_load),
        .burst_start (burst_start),
        .beat_step   (beat_step),
        .beat_addr   (beat_addr),
        .beat_last   (beat_last)
    );

    led_reg_slave u_led_reg_slave (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .beat_addr (beat_addr),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .wr_strb   (wr_strb),
        .rd_data   (rd_data),
        .reg_bank  (reg_bank)
    );

    led_page_display u_led_page_display (
        .sys_clk  (sys_clk),
        .rst_n    (rst_n),
        .reg_bank (reg_bank),
        .btn_up   (btn_up),
        .btn_down (btn_down),
        .led8     (led8),
        .led4     (led4)
    );

endmodule

/* src/led_page_display.sv */
`timescale 1ns/10ps

module led_page_display (
    input  logic               sys_clk,
    input  logic               rst_n,
    input  led_pkg::reg_bank_t reg_bank,
    input  logic               btn_up,
    input  logic               btn_down,
    output led_pkg::led_byte_t led8,
    output led_pkg::page_idx_t led4
);
    import led_pkg::*;

    logic      up_q;
    logic      down_q;
    logic      up_rise;
    logic      down_rise;
    page_idx_t idx;

    // previous button samples
    always_ff @(posedge sys_clk) begin
        up_q   <= btn_up;
        down_q <= btn_down;
    end

    assign up_rise   = btn_up && !up_q;
    assign down_rise = btn_down && !down_q;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            idx <= '0;
        end else if (up_rise && !down_rise) begin
            idx <= idx + page_idx_t'(1);    // wraps 15 to 0
        end else if (down_rise && !up_rise) begin
            idx <= idx - page_idx_t'(1);
        end
    end

    // byte idx%4 of register idx/4 is simply byte idx of the bank
    assign led8 = reg_bank[idx*8 +: 8];
    assign led4 = idx;

endmodule

/* src/led_reg_slave.sv */
`timescale 1ns/10ps

module led_reg_slave (
    input  logic               sys_clk,
    input  logic               rst_n,
    input  bus_pkg::addr_t     beat_addr,
    input  logic               wr_en,
    input  bus_pkg::data_t     wr_data,
    input  bus_pkg::strb_t     wr_strb,
    output bus_pkg::data_t     rd_data,
    output led_pkg::reg_bank_t reg_bank
);
    import led_pkg::*;

    localparam int SEL_W = $clog2(REG_COUNT);

    logic [SEL_W-1:0] sel;

    // word select, higher offset bits alias
    assign sel = beat_addr[SEL_W+1:2];

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            reg_bank <= '0;
        end else if (wr_en) begin
            for (int i = 0; i < $bits(wr_strb); i++) begin
                if (wr_strb[i]) begin
                    reg_bank[sel*32 + i*8 +: 8] <= wr_data[i*8 +: 8];
                end
            end
        end
    end

    assign rd_data = reg_bank[sel*32 +: 32];

endmodule

/* bus/bus_fsm.sv */
`timescale 1ns/10ps

module bus_fsm #(
    parameter bus_pkg::addr_t LED_START_ADDR = 32'h2000_0000,
    parameter bus_pkg::addr_t LED_END_ADDR   = 32'h2fff_ff0f
) (
    input  logic            sys_clk,
    input  logic            rst_n,
    input  bus_pkg::aw_t    aw,
    output logic            aw_ready,
    input  bus_pkg::w_t     w,
    output logic            w_ready,
    output bus_pkg::b_t     b,
    input  logic            b_ready,
    input  bus_pkg::ar_t    ar,
    output logic            ar_ready,
    output bus_pkg::r_t     r,
    input  logic            r_ready,
    output logic            burst_load,
    output bus_pkg::burst_t burst_start,
    output logic            beat_step,
    input  bus_pkg::addr_t  beat_addr,
    input  logic            beat_last,
    output logic            wr_en,
    output bus_pkg::data_t  wr_data,
    output bus_pkg::strb_t  wr_strb,
    input  bus_pkg::data_t  rd_data
);
    import bus_pkg::*;

    typedef enum logic [1:0] {IDLE, WR_DATA, WR_RESP, RD_DATA} state_t;

    state_t state;
    state_t state_nxt;
    logic   first_beat;    // counter still holds the start address
    logic   hit_q;
    logic   hit;

    // window compare runs on the registered start address, not the input port
    assign hit = first_beat ? (beat_addr >= LED_START_ADDR && beat_addr <= LED_END_ADDR)
                            : hit_q;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            first_beat <= 1'b0;
            hit_q      <= 1'b0;
        end else begin
            state <= state_nxt;
            if (burst_load) begin
                first_beat <= 1'b1;
            end else if (beat_step) begin
                first_beat <= 1'b0;
            end
            if (first_beat && beat_step) begin
                hit_q <= hit;    // held for the rest of the burst
            end
        end
    end

    always_comb begin
        state_nxt   = state;
        aw_ready    = 1'b0;
        ar_ready    = 1'b0;
        w_ready     = 1'b0;
        burst_load  = 1'b0;
        beat_step   = 1'b0;
        burst_start = '{addr: aw.addr, len: aw.len};
        b           = '0;
        r           = '0;
        case (state)
            IDLE: begin
                if (aw.valid) begin    // write wins
                    aw_ready   = 1'b1;
                    burst_load = 1'b1;
                    state_nxt  = WR_DATA;
                end else if (ar.valid) begin
                    ar_ready    = 1'b1;
                    burst_load  = 1'b1;
                    burst_start = '{addr: ar.addr, len: ar.len};
                    state_nxt   = RD_DATA;
                end
            end
            WR_DATA: begin
                w_ready = 1'b1;
                if (w.valid) begin
                    beat_step = 1'b1;
                    if (beat_last) begin
                        state_nxt = WR_RESP;
                    end
                end
            end
            WR_RESP: begin
                b.valid = 1'b1;
                b.resp  = hit ? RESP_OKAY : RESP_DECERR;
                if (b_ready) begin
                    state_nxt = IDLE;
                end
            end
            RD_DATA: begin
                r.valid = 1'b1;
                r.data  = hit ? rd_data : '0;    // misses read as zero
                r.resp  = hit ? RESP_OKAY : RESP_DECERR;
                r.last  = beat_last;
                if (r_ready) begin
                    beat_step = 1'b1;
                    if (beat_last) begin
                        state_nxt = IDLE;
                    end
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // miss bursts still take their beats, data dropped
    assign wr_en   = w_ready && w.valid && hit;
    assign wr_data = w.data;
    assign wr_strb = w.strb;

endmodule

/* bus/burst_counter.sv */
`timescale 1ns/10ps

module burst_counter (
    input  logic            sys_clk,
    input  logic            rst_n,
    input  logic            burst_load,
    input  bus_pkg::burst_t burst_start,
    input  logic            beat_step,
    output bus_pkg::addr_t  beat_addr,
    output logic            beat_last
);
    import bus_pkg::*;

    len_t beats_left;    // beats after the current one

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            beat_addr  <= '0;
            beats_left <= '0;
        end else if (burst_load) begin
            beat_addr  <= burst_start.addr;
            beats_left <= burst_start.len;
        end else if (beat_step) begin
            // incr only, one word per beat
            beat_addr  <= beat_addr + addr_t'(4);
            beats_left <= beats_left - len_t'(1);
        end
    end

    assign beat_last = (beats_left == '0);

endmodule

/* common/led_pkg.sv */
package led_pkg;

    localparam int REG_COUNT = 4;

    typedef logic [7:0] led_byte_t;
    typedef logic [3:0] page_idx_t;    // 16 bytes per page

    // register k sits at bits 32k+31:32k
    typedef logic [REG_COUNT*32-1:0] reg_bank_t;

endpackage

/* common/bus_pkg.sv */
package bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [7:0]  len_t;    // beats minus one
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    typedef struct packed {
        logic  valid;
        addr_t addr;
        len_t  len;
    } aw_t;

    typedef struct packed {
        logic  valid;
        data_t data;
        strb_t strb;
    } w_t;

    typedef struct packed {
        logic  valid;
        resp_t resp;
    } b_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
        len_t  len;
    } ar_t;

    typedef struct packed {
        logic  valid;
        data_t data;
        resp_t resp;
        logic  last;
    } r_t;

    // what the counter needs to start a burst
    typedef struct packed {
        addr_t addr;
        len_t  len;
    } burst_t;

endpackage
